/* hw/img_pkg.sv */
`default_nettype none

package img_pkg;

   // host command codes
   localparam logic [7:0] CMD_PARAM           = 8'd0;
   localparam logic [7:0] CMD_SEND_IMG        = 8'd1;
   localparam logic [7:0] CMD_READ_IMG        = 8'd2;
   localparam logic [7:0] CMD_GET_STATUS      = 8'd3;
   localparam logic [7:0] CMD_APPLY_ADD       = 8'd4;
   localparam logic [7:0] CMD_APPLY_THRESHOLD = 8'd5;
   localparam logic [7:0] CMD_SWITCH_BUFFERS  = 8'd6;
   localparam logic [7:0] CMD_APPLY_INVERT    = 8'd8;

   // byte address width of the word memory
   localparam int ADDR_W = 32;

   // width times height truncated to 16 bits
   typedef logic [15:0] pix_count_t;

   // one memory word with the low pixel at the lower byte address
   typedef struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
   } pixel_pair_t;

   typedef union packed {
      logic [15:0] raw;
      pixel_pair_t pix;
   } pixel_word_u;

   typedef enum logic [1:0] {
      OP_ADD,
      OP_THRESHOLD,
      OP_INVERT
   } unary_op_e;

   typedef struct packed {
      unary_op_e   kind;
      logic [15:0] add_value;
      logic        clamp;
      logic [7:0]  thr_value;
      logic [7:0]  thr_repl;
      logic        upper;
   } op_cfg_t;

   typedef struct packed {
      logic [ADDR_W-1:0] input_base;
      logic [ADDR_W-1:0] storage_base;
   } buf_bases_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              wr;
      logic              rd;
      pixel_word_u       wdata;
   } mem_req_t;

endpackage

`default_nettype wire

/* hw/host_cmd_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module host_cmd_decoder
   import img_pkg::*;
#(
   parameter int MEM_BYTES = 131072
) (
   input  wire              clk,
   input  wire              rst_n,
   input  wire  [7:0]       comm_cmd,
   input  wire  [7:0]       comm_data_in,
   input  wire              comm_data_in_valid,
   input  wire              stream_done,
   output mem_req_t         upload_req,
   output buf_bases_t       bufs,
   output op_cfg_t          op_cfg,
   output pix_count_t       pix_count,
   output logic             op_start,
   output logic             stream_start,
   output logic             stream_status
);

   // second buffer sits in the upper half of memory
   localparam logic [ADDR_W-1:0] BUF2_BASE = ADDR_W'(MEM_BYTES / 2);

   typedef enum logic [2:0] {
      S_CMD,
      S_SIZE,
      S_UPLOAD,
      S_ADD,
      S_THR,
      S_STREAM
   } state_e;

   state_e            state;
   pix_count_t        byte_cnt;
   logic [15:0]       img_width;
   logic [15:0]       img_height;
   logic [7:0]        lo_hold;
   logic              up_wr;
   logic [ADDR_W-1:0] up_addr;
   pixel_word_u       up_word;

   assign pix_count = img_width * img_height;

   assign upload_req = '{addr: up_addr, wr: up_wr, rd: 1'b0, wdata: up_word};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state         <= S_CMD;
         byte_cnt      <= '0;
         img_width     <= '0;
         img_height    <= '0;
         bufs          <= '{input_base: '0, storage_base: BUF2_BASE};
         op_cfg        <= '0;
         op_start      <= 1'b0;
         stream_start  <= 1'b0;
         stream_status <= 1'b0;
         up_wr         <= 1'b0;
      end else begin
         op_start     <= 1'b0;
         stream_start <= 1'b0;
         up_wr        <= 1'b0;
         case (state)
            S_CMD: begin
               if (comm_data_in_valid) begin
                  byte_cnt <= '0;
                  case (comm_cmd)
                     CMD_PARAM: begin
                        state <= S_SIZE;
                        bufs  <= '{input_base: '0, storage_base: BUF2_BASE};
                     end
                     CMD_SEND_IMG: begin
                        if (pix_count != '0) begin
                           state <= S_UPLOAD;
                        end
                     end
                     CMD_READ_IMG: begin
                        state         <= S_STREAM;
                        stream_start  <= 1'b1;
                        stream_status <= 1'b0;
                     end
                     CMD_GET_STATUS: begin
                        state         <= S_STREAM;
                        stream_start  <= 1'b1;
                        stream_status <= 1'b1;
                     end
                     CMD_APPLY_ADD: begin
                        state       <= S_ADD;
                        op_cfg.kind <= OP_ADD;
                     end
                     CMD_APPLY_THRESHOLD: begin
                        state       <= S_THR;
                        op_cfg.kind <= OP_THRESHOLD;
                     end
                     CMD_SWITCH_BUFFERS: begin
                        bufs <= '{input_base: bufs.storage_base,
                                  storage_base: bufs.input_base};
                     end
                     CMD_APPLY_INVERT: begin
                        op_cfg.kind <= OP_INVERT;
                        op_start    <= 1'b1;
                     end
                     // unsupported codes are dropped
                     default: ;
                  endcase
               end
            end
            // width then height, low byte first
            S_SIZE: begin
               if (comm_data_in_valid) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  case (byte_cnt[1:0])
                     2'd0: img_width[7:0]   <= comm_data_in;
                     2'd1: img_width[15:8]  <= comm_data_in;
                     2'd2: img_height[7:0]  <= comm_data_in;
                     default: begin
                        img_height[15:8] <= comm_data_in;
                        state            <= S_CMD;
                     end
                  endcase
               end
            end
            S_UPLOAD: begin
               if (comm_data_in_valid) begin
                  // a word goes out on every odd byte
                  up_wr    <= byte_cnt[0];
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == pix_count - 1'b1) begin
                     state <= S_CMD;
                  end
               end
            end
            S_ADD: begin
               if (comm_data_in_valid) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  case (byte_cnt[1:0])
                     2'd0: op_cfg.add_value[7:0]  <= comm_data_in;
                     2'd1: op_cfg.add_value[15:8] <= comm_data_in;
                     default: begin
                        op_cfg.clamp <= comm_data_in[0];
                        op_start     <= 1'b1;
                        state        <= S_CMD;
                     end
                  endcase
               end
            end
            S_THR: begin
               if (comm_data_in_valid) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  case (byte_cnt[1:0])
                     2'd0: op_cfg.thr_value <= comm_data_in;
                     2'd1: op_cfg.thr_repl  <= comm_data_in;
                     default: begin
                        op_cfg.upper <= comm_data_in[0];
                        op_start     <= 1'b1;
                        state        <= S_CMD;
                     end
                  endcase
               end
            end
            // host bytes are ignored while the streamer owns the reply
            S_STREAM: begin
               if (stream_done) begin
                  state <= S_CMD;
               end
            end
            default: state <= S_CMD;
         endcase
      end
   end

   // upload byte pairing, low byte first
   always_ff @(posedge clk) begin
      if (state == S_UPLOAD && comm_data_in_valid) begin
         if (!byte_cnt[0]) begin
            lo_hold <= comm_data_in;
         end else begin
            up_addr     <= bufs.input_base + ADDR_W'({byte_cnt[15:1], 1'b0});
            up_word.raw <= {comm_data_in, lo_hold};
         end
      end
   end

endmodule

`default_nettype wire

/* hw/pixel_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_engine
   import img_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire              op_start,
   input  wire  op_cfg_t    op_cfg,
   input  wire  pix_count_t pix_count,
   input  wire  buf_bases_t bufs,
   input  wire              engine_grant,
   input  wire  [15:0]      data_read,
   input  wire              data_read_valid,
   output mem_req_t         engine_req,
   output logic             engine_busy
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_RD,
      S_WAIT,
      S_WR
   } state_e;

   state_e            state;
   logic [ADDR_W-1:0] word_addr;
   pix_count_t        words_left;
   pixel_word_u       rd_word;
   pixel_word_u       result;
   pixel_word_u       wr_word;

   // 16-bit signed sum, clamped to the pixel range on request
   function automatic logic [7:0] add_pix(input logic [7:0] p, input op_cfg_t cfg);
      logic signed [15:0] sum;
      sum = signed'({8'h00, p}) + signed'(cfg.add_value);
      if (cfg.clamp && sum > 16'sd255) begin
         return 8'hff;
      end
      if (cfg.clamp && sum < 16'sd0) begin
         return 8'h00;
      end
      return sum[7:0];
   endfunction

   function automatic logic [7:0] thr_pix(input logic [7:0] p, input op_cfg_t cfg);
      logic hit;
      hit = cfg.upper ? (p >= cfg.thr_value) : (p <= cfg.thr_value);
      return hit ? cfg.thr_repl : p;
   endfunction

   assign rd_word = data_read;

   always_comb begin
      result = rd_word;
      case (op_cfg.kind)
         OP_ADD: begin
            result.pix.lo = add_pix(rd_word.pix.lo, op_cfg);
            result.pix.hi = add_pix(rd_word.pix.hi, op_cfg);
         end
         OP_THRESHOLD: begin
            result.pix.lo = thr_pix(rd_word.pix.lo, op_cfg);
            result.pix.hi = thr_pix(rd_word.pix.hi, op_cfg);
         end
         OP_INVERT: result.raw = ~rd_word.raw;
         default: ;
      endcase
   end

   assign engine_busy = (state != S_IDLE);

   assign engine_req = '{addr: word_addr, wr: (state == S_WR), rd: (state == S_RD),
                         wdata: wr_word};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= S_IDLE;
         word_addr  <= '0;
         words_left <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (op_start && pix_count[15:1] != '0) begin
                  state      <= S_RD;
                  word_addr  <= bufs.storage_base;
                  words_left <= {1'b0, pix_count[15:1]};
               end
            end
            S_RD: begin
               if (engine_grant) begin
                  state <= S_WAIT;
               end
            end
            S_WAIT: begin
               if (data_read_valid) begin
                  state <= S_WR;
               end
            end
            // write back in place, then move to the next word
            S_WR: begin
               if (engine_grant) begin
                  if (words_left == 16'd1) begin
                     state <= S_IDLE;
                  end else begin
                     state      <= S_RD;
                     words_left <= words_left - 1'b1;
                     word_addr  <= word_addr + ADDR_W'(2);
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_WAIT && data_read_valid) begin
         wr_word <= result;
      end
   end

endmodule

`default_nettype wire

/* hw/image_streamer.sv */
`timescale 1ns/100ps
`default_nettype none

module image_streamer
   import img_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire              stream_start,
   input  wire              stream_status,
   input  wire  pix_count_t pix_count,
   input  wire  buf_bases_t bufs,
   input  wire              engine_busy,
   input  wire              comm_data_out_free,
   input  wire  [15:0]      data_read,
   input  wire              data_read_valid,
   output mem_req_t         stream_req,
   output logic [7:0]       comm_data_out,
   output logic             comm_data_out_valid,
   output logic             stream_done
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_STATUS,
      S_RD_REQ,
      S_RD_WAIT,
      S_SEND_LO,
      S_SEND_HI
   } state_e;

   state_e            state;
   pix_count_t        cnt;
   logic [ADDR_W-1:0] rd_addr;
   pixel_word_u       rd_word;
   logic [7:0]        status_byte;

   // status reply, busy flag in bit 0 of the first byte
   always_comb begin
      case (cnt[1:0])
         2'd0: status_byte = {7'b0001000, engine_busy};
         2'd1: status_byte = 8'h22;
         2'd2: status_byte = 8'h33;
         default: status_byte = 8'h44;
      endcase
   end

   assign stream_req = '{addr: rd_addr, wr: 1'b0, rd: (state == S_RD_REQ), wdata: '0};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state               <= S_IDLE;
         cnt                 <= '0;
         rd_addr             <= '0;
         comm_data_out       <= '0;
         comm_data_out_valid <= 1'b0;
         stream_done         <= 1'b0;
      end else begin
         comm_data_out_valid <= 1'b0;
         stream_done         <= 1'b0;
         case (state)
            S_IDLE: begin
               if (stream_start) begin
                  cnt     <= '0;
                  rd_addr <= bufs.input_base;
                  if (stream_status) begin
                     state <= S_STATUS;
                  end else if (pix_count != '0) begin
                     state <= S_RD_REQ;
                  end else begin
                     stream_done <= 1'b1;
                  end
               end
            end
            S_STATUS: begin
               if (comm_data_out_free) begin
                  comm_data_out       <= status_byte;
                  comm_data_out_valid <= 1'b1;
                  cnt                 <= cnt + 1'b1;
                  if (cnt[1:0] == 2'd3) begin
                     state       <= S_IDLE;
                     stream_done <= 1'b1;
                  end
               end
            end
            S_RD_REQ: state <= S_RD_WAIT;
            S_RD_WAIT: begin
               if (data_read_valid) begin
                  state <= S_SEND_LO;
               end
            end
            S_SEND_LO: begin
               if (comm_data_out_free) begin
                  comm_data_out       <= rd_word.pix.lo;
                  comm_data_out_valid <= 1'b1;
                  state               <= S_SEND_HI;
               end
            end
            S_SEND_HI: begin
               if (comm_data_out_free) begin
                  comm_data_out       <= rd_word.pix.hi;
                  comm_data_out_valid <= 1'b1;
                  cnt                 <= cnt + 16'd2;
                  rd_addr             <= rd_addr + ADDR_W'(2);
                  if (cnt == pix_count - 16'd2) begin
                     state       <= S_IDLE;
                     stream_done <= 1'b1;
                  end else begin
                     state <= S_RD_REQ;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_RD_WAIT && data_read_valid) begin
         rd_word <= data_read;
      end
   end

endmodule

`default_nettype wire

/* hw/mem_port_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_port_arbiter
   import img_pkg::*;
(
   input  wire               clk,
   input  wire               rst_n,
   input  wire  mem_req_t    upload_req,
   input  wire  mem_req_t    stream_req,
   input  wire  mem_req_t    engine_req,
   output logic              engine_grant,
   output logic [ADDR_W-1:0] addr,
   output logic              wr_en,
   output logic              rd_en,
   output logic [15:0]       data_write
);

   logic     up_act;
   logic     st_act;
   mem_req_t sel;

   assign up_act = upload_req.wr | upload_req.rd;
   assign st_act = stream_req.wr | stream_req.rd;

   // engine only wins when the host side is quiet
   assign engine_grant = ~(up_act | st_act);

   always_comb begin
      if (up_act) begin
         sel = upload_req;
      end else if (st_act) begin
         sel = stream_req;
      end else begin
         sel = engine_req;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_en <= 1'b0;
         rd_en <= 1'b0;
      end else begin
         wr_en <= sel.wr;
         rd_en <= sel.rd;
      end
   end

   always_ff @(posedge clk) begin
      addr       <= sel.addr;
      data_write <= sel.wdata.raw;
   end

endmodule

`default_nettype wire

/* hw/image_processor.sv */
`timescale 1ns/100ps
`default_nettype none

module image_processor
   import img_pkg::*;
#(
   parameter int MEM_BYTES = 131072
) (
   input  wire               clk,
   input  wire               rst_n,
   input  wire  [7:0]        comm_cmd,
   input  wire  [7:0]        comm_data_in,
   input  wire               comm_data_in_valid,
   input  wire               comm_data_out_free,
   output logic [7:0]        comm_data_out,
   output logic              comm_data_out_valid,
   output logic [ADDR_W-1:0] addr,
   output logic              wr_en,
   output logic              rd_en,
   output logic [15:0]       data_write,
   input  wire  [15:0]       data_read,
   input  wire               data_read_valid
);

   mem_req_t   upload_req;
   mem_req_t   stream_req;
   mem_req_t   engine_req;
   buf_bases_t bufs;
   op_cfg_t    op_cfg;
   pix_count_t pix_count;
   logic       op_start;
   logic       stream_start;
   logic       stream_status;
   logic       stream_done;
   logic       engine_busy;
   logic       engine_grant;

   host_cmd_decoder #(
      .MEM_BYTES (MEM_BYTES)
   ) decoder_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .comm_cmd           (comm_cmd),
      .comm_data_in       (comm_data_in),
      .comm_data_in_valid (comm_data_in_valid),
      .stream_done        (stream_done),
      .upload_req         (upload_req),
      .bufs               (bufs),
      .op_cfg             (op_cfg),
      .pix_count          (pix_count),
      .op_start           (op_start),
      .stream_start       (stream_start),
      .stream_status      (stream_status)
   );

   pixel_engine engine_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .op_start        (op_start),
      .op_cfg          (op_cfg),
      .pix_count       (pix_count),
      .bufs            (bufs),
      .engine_grant    (engine_grant),
      .data_read       (data_read),
      .data_read_valid (data_read_valid),
      .engine_req      (engine_req),
      .engine_busy     (engine_busy)
   );

   image_streamer streamer_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .stream_start        (stream_start),
      .stream_status       (stream_status),
      .pix_count           (pix_count),
      .bufs                (bufs),
      .engine_busy         (engine_busy),
      .comm_data_out_free  (comm_data_out_free),
      .data_read           (data_read),
      .data_read_valid     (data_read_valid),
      .stream_req          (stream_req),
      .comm_data_out       (comm_data_out),
      .comm_data_out_valid (comm_data_out_valid),
      .stream_done         (stream_done)
   );

   mem_port_arbiter arbiter_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .upload_req   (upload_req),
      .stream_req   (stream_req),
      .engine_req   (engine_req),
      .engine_grant (engine_grant),
      .addr         (addr),
      .wr_en        (wr_en),
      .rd_en        (rd_en),
      .data_write   (data_write)
   );

endmodule

`default_nettype wire

/* tests/image_processor_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module image_processor_assert (
   input wire clk,
   input wire rst_n,
   input wire wr_en,
   input wire rd_en,
   input wire comm_data_out_free,
   input wire comm_data_out_valid
);

   int unsigned violations = 0;

   // one memory strobe per cycle on the shared port
   wr_rd_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && rd_en))
      else begin
         $error("wr_en and rd_en are high in the same cycle");
         violations++;
      end

   // a reply byte only goes out after the host had room for it
   out_after_free: assert property (@(posedge clk) disable iff (!rst_n)
      comm_data_out_valid |-> $past(comm_data_out_free))
      else begin
         $error("comm_data_out_valid without comm_data_out_free in the cycle before");
         violations++;
      end

   quiet_in_reset: assert property (@(posedge clk)
      !rst_n |-> !(wr_en || rd_en || comm_data_out_valid))
      else begin
         $error("a strobe is high while rst_n is low");
         violations++;
      end

endmodule

bind image_processor image_processor_assert props_i (
   .clk                 (clk),
   .rst_n               (rst_n),
   .wr_en               (wr_en),
   .rd_en               (rd_en),
   .comm_data_out_free  (comm_data_out_free),
   .comm_data_out_valid (comm_data_out_valid)
);

`default_nettype wire

/* tests/tb_image_processor.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_image_processor
   import img_pkg::*;
();

   localparam int MEM_BYTES     = 4096;
   localparam int WORDS         = MEM_BYTES / 2;
   localparam int WORD_AW       = 11;
   localparam int REPLY_TIMEOUT = 200;
   localparam int POLL_LIMIT    = 2000;
   localparam int ROUNDS        = 3;

   logic              clk = 1'b0;
   logic              rst_n;
   logic [7:0]        comm_cmd;
   logic [7:0]        comm_data_in;
   logic              comm_data_in_valid;
   logic              comm_data_out_free;
   logic [7:0]        comm_data_out;
   logic              comm_data_out_valid;
   logic [ADDR_W-1:0] addr;
   logic              wr_en;
   logic              rd_en;
   logic [15:0]       data_write;
   logic [15:0]       data_read;
   logic              data_read_valid;

   // behavioral memory and its pending read
   logic [15:0]        mem_words [0:WORDS-1];
   logic [WORD_AW-1:0] rd_index;
   int                 rd_left = 0;

   // byte addressed reference model of both buffers
   logic [7:0] model_mem [0:MEM_BYTES-1];
   int         in_base;
   int         st_base;
   int         pix;
   logic [7:0] reply [$];

   image_processor #(
      .MEM_BYTES (MEM_BYTES)
   ) dut_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .comm_cmd            (comm_cmd),
      .comm_data_in        (comm_data_in),
      .comm_data_in_valid  (comm_data_in_valid),
      .comm_data_out_free  (comm_data_out_free),
      .comm_data_out       (comm_data_out),
      .comm_data_out_valid (comm_data_out_valid),
      .addr                (addr),
      .wr_en               (wr_en),
      .rd_en               (rd_en),
      .data_write          (data_write),
      .data_read           (data_read),
      .data_read_valid     (data_read_valid)
   );

   always #4 clk = ~clk;

   // reads come back after 1 to 4 cycles
   always begin
      logic              do_wr;
      logic              do_rd;
      logic [ADDR_W-1:0] req_addr;
      logic [15:0]       req_data;
      @(posedge clk);
      do_wr    = wr_en;
      do_rd    = rd_en;
      req_addr = addr;
      req_data = data_write;
      #1;
      data_read_valid = 1'b0;
      if (rd_left > 0) begin
         rd_left--;
         if (rd_left == 0) begin
            data_read       = mem_words[rd_index];
            data_read_valid = 1'b1;
         end
      end
      if (do_wr) begin
         mem_words[req_addr[WORD_AW:1]] = req_data;
      end
      if (do_rd) begin
         rd_index = req_addr[WORD_AW:1];
         rd_left  = $urandom_range(1, 4);
      end
   end

   always @(posedge clk) begin
      if (dut_i.props_i.violations != 0) begin
         stop_run("a protocol assertion failed");
      end
   end

   function automatic logic [15:0] fill_word(input int i);
      return 16'(i * 40503) ^ 16'h5a5a;
   endfunction

   function automatic logic [7:0] add_ref(input logic [7:0] p, input logic [15:0] value,
                                          input logic clamp);
      int sum;
      sum = int'(p) + int'($signed(value));
      // wraps like a 16-bit signed adder
      sum = int'(shortint'(sum));
      if (clamp && sum > 255) begin
         return 8'hff;
      end
      if (clamp && sum < 0) begin
         return 8'h00;
      end
      return sum[7:0];
   endfunction

   function automatic logic [7:0] thr_ref(input logic [7:0] p, input logic [7:0] value,
                                          input logic [7:0] repl, input logic upper);
      if (upper ? (p >= value) : (p <= value)) begin
         return repl;
      end
      return p;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp));
      end
   endtask

   task automatic check_word(input string name, input pixel_word_u got,
                             input pixel_word_u exp);
      if (got.raw !== exp.raw) begin
         stop_run($sformatf("FAILED %s: got 0x%04h, expected 0x%04h", name, got.raw, exp.raw));
      end
   endtask

   task automatic pulse_valid();
      comm_data_in_valid = 1'b1;
      @(posedge clk);
      #1;
      comm_data_in_valid = 1'b0;
   endtask

   task automatic send_cmd(input logic [7:0] code);
      comm_cmd = code;
      pulse_valid();
   endtask

   task automatic send_data(input logic [7:0] data);
      comm_data_in = data;
      pulse_valid();
   endtask

   // gathers n reply bytes with optional random back-pressure
   task automatic collect_reply(input int n, input logic random_free);
      int waited;
      reply.delete();
      waited = 0;
      while (reply.size() < n) begin
         if (comm_data_out_valid) begin
            reply.push_back(comm_data_out);
            waited = 0;
         end
         if (waited > REPLY_TIMEOUT) begin
            stop_run("timed out waiting for a reply byte on comm_data_out");
         end
         comm_data_out_free = random_free ? ($urandom_range(0, 2) != 0) : 1'b1;
         @(posedge clk);
         #1;
         waited++;
      end
      comm_data_out_free = 1'b1;
      if (comm_data_out_valid) begin
         stop_run("the DUT sent more reply bytes than expected");
      end
   endtask

   task automatic get_status(output logic busy);
      send_cmd(CMD_GET_STATUS);
      collect_reply(4, 1'b0);
      check_byte("comm_data_out[status 0]", {reply[0][7:1], 1'b0}, 8'h10);
      check_byte("comm_data_out[status 1]", reply[1], 8'h22);
      check_byte("comm_data_out[status 2]", reply[2], 8'h33);
      check_byte("comm_data_out[status 3]", reply[3], 8'h44);
      busy = reply[0][0];
   endtask

   task automatic wait_engine_idle();
      logic busy;
      int   polls;
      get_status(busy);
      if (!busy) begin
         stop_run("the engine did not report busy after an operation was started");
      end
      polls = 0;
      while (busy) begin
         if (polls > POLL_LIMIT) begin
            stop_run("the engine stayed busy past the polling limit");
         end
         get_status(busy);
         polls++;
      end
   endtask

   task automatic set_size(input logic [15:0] width, input logic [15:0] height);
      send_cmd(CMD_PARAM);
      send_data(width[7:0]);
      send_data(width[15:8]);
      send_data(height[7:0]);
      send_data(height[15:8]);
      pix     = int'(16'(width * height));
      in_base = 0;
      st_base = MEM_BYTES / 2;
   endtask

   task automatic upload_image();
      logic [7:0] b;
      send_cmd(CMD_SEND_IMG);
      for (int i = 0; i < pix; i++) begin
         b = 8'($urandom);
         send_data(b);
         model_mem[in_base + i] = b;
      end
   endtask

   task automatic read_image();
      send_cmd(CMD_READ_IMG);
      collect_reply(pix, 1'b1);
      for (int i = 0; i < pix; i++) begin
         check_byte($sformatf("comm_data_out[pixel %0d]", i), reply[i], model_mem[in_base + i]);
      end
   endtask

   task automatic switch_buffers();
      int t;
      send_cmd(CMD_SWITCH_BUFFERS);
      t       = in_base;
      in_base = st_base;
      st_base = t;
   endtask

   task automatic apply_add(input logic [15:0] value, input logic clamp);
      send_cmd(CMD_APPLY_ADD);
      send_data(value[7:0]);
      send_data(value[15:8]);
      send_data({7'($urandom), clamp});
      for (int i = 0; i < pix; i++) begin
         model_mem[st_base + i] = add_ref(model_mem[st_base + i], value, clamp);
      end
      wait_engine_idle();
   endtask

   task automatic apply_threshold(input logic [7:0] value, input logic [7:0] repl,
                                  input logic upper);
      send_cmd(CMD_APPLY_THRESHOLD);
      send_data(value);
      send_data(repl);
      send_data({7'($urandom), upper});
      for (int i = 0; i < pix; i++) begin
         model_mem[st_base + i] = thr_ref(model_mem[st_base + i], value, repl, upper);
      end
      wait_engine_idle();
   endtask

   task automatic apply_invert();
      send_cmd(CMD_APPLY_INVERT);
      for (int i = 0; i < pix; i++) begin
         model_mem[st_base + i] = ~model_mem[st_base + i];
      end
      wait_engine_idle();
   endtask

   // compares every memory word against the model
   task automatic check_memory();
      pixel_word_u got;
      pixel_word_u exp;
      for (int i = 0; i < WORDS; i++) begin
         got.raw = mem_words[i];
         exp.raw = {model_mem[2 * i + 1], model_mem[2 * i]};
         check_word($sformatf("mem[0x%03h]", 2 * i), got, exp);
      end
   endtask

   initial begin
      logic        busy;
      logic [15:0] width;
      logic [15:0] height;
      void'($urandom(32'hb12f));
      rst_n              = 1'b1;
      comm_cmd           = '0;
      comm_data_in       = '0;
      comm_data_in_valid = 1'b0;
      comm_data_out_free = 1'b1;
      data_read          = '0;
      data_read_valid    = 1'b0;
      for (int i = 0; i < WORDS; i++) begin
         mem_words[i]          = fill_word(i);
         model_mem[2 * i]      = mem_words[i][7:0];
         model_mem[2 * i + 1]  = mem_words[i][15:8];
      end
      in_base = 0;
      st_base = MEM_BYTES / 2;
      pix     = 0;
      #2;
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      get_status(busy);
      check_byte("comm_data_out[status 0]", reply[0], 8'h10);

      for (int r = 0; r < ROUNDS; r++) begin
         width  = 16'(2 * $urandom_range(1, 16));
         height = 16'($urandom_range(1, 32));
         set_size(width, height);
         upload_image();
         read_image();

         switch_buffers();
         apply_add(16'($urandom_range(0, 599)) - 16'd300, 1'($urandom));
         switch_buffers();
         read_image();

         switch_buffers();
         apply_threshold(8'($urandom), 8'($urandom), 1'($urandom));
         switch_buffers();
         read_image();

         switch_buffers();
         apply_invert();
         switch_buffers();
         read_image();
         check_memory();
      end

      // code 11 belongs to a dropped function
      send_cmd(8'd11);
      get_status(busy);
      check_byte("comm_data_out[status 0]", reply[0], 8'h10);
      read_image();
      check_memory();

      if (dut_i.props_i.violations != 0) begin
         stop_run("a protocol assertion failed during the run");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* filelist.f */
hw/img_pkg.sv
hw/host_cmd_decoder.sv
hw/pixel_engine.sv
hw/image_streamer.sv
hw/mem_port_arbiter.sv
hw/image_processor.sv
tests/image_processor_assert.sv
tests/tb_image_processor.sv
